/* verilog.f */
src/mem_pkg.sv
src/lsu_decode.sv
src/apb_bus_master.sv
src/mem_stage.sv
src/data_ram.sv
src/mem_top.sv
verification/mem_assert.sv
verification/mem_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - src/mem_pkg.sv
  - src/lsu_decode.sv
  - src/apb_bus_master.sv
  - src/mem_stage.sv
  - src/data_ram.sv
  - src/mem_top.sv
  - target: test
    files:
      - verification/mem_assert.sv
      - verification/mem_tb.sv

/* verification/mem_tb.sv */
`default_nettype none

module mem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int unsigned mem_words    = 256;
    localparam int unsigned wait_cycles  = 1;
    localparam int unsigned reset_cycles = 4;
    localparam int unsigned n_uops       = 287;
    localparam int unsigned max_cycles   = 20 * n_uops + reset_cycles;

    logic clk = 1'b0;
    logic rstn;
    uop_t uop;
    logic stall;
    uop_t wb_uop;

    logic [7:0] ref_mem [mem_words*4];  // byte mirror of the RAM
    uop_t       exp_q [$];
    integer     seed = 32'h1eba_3b47;
    int         errors = 0;
    int         cycles = 0;
    logic [5:0] tag_cnt = '0;

    always #4 clk = ~clk;

    mem_top #(
        .mem_words   ( mem_words   ),
        .wait_cycles ( wait_cycles )
    ) mem_top_inst (
        .clk_i    ( clk    ),
        .rstn_i   ( rstn   ),
        .uop_i    ( uop    ),
        .stall_o  ( stall  ),
        .wb_uop_o ( wb_uop )
    );

    function automatic logic [31:0] align_addr(input mem_op_e op, input logic [31:0] a);
        case (op)
            op_lh, op_lhu, op_sh: return {a[31:1], 1'b0};
            op_lw, op_sw:         return {a[31:2], 2'b00};
            default:              return a;
        endcase
    endfunction

    // little endian, lane n holds byte address n
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] a);
        int unsigned i;
        logic [7:0]  b0;
        logic [7:0]  b1;
        i  = a % (mem_words * 4);
        b0 = ref_mem[i];
        b1 = ref_mem[(i + 1) % (mem_words * 4)];
        case (op)
            op_lb:   return {{24{b0[7]}}, b0};
            op_lbu:  return {24'h0, b0};
            op_lh:   return {{16{b1[7]}}, b1, b0};
            op_lhu:  return {16'h0, b1, b0};
            default: return {ref_mem[i+3], ref_mem[i+2], b1, b0};
        endcase
    endfunction

    task automatic ref_store(input mem_op_e op, input logic [31:0] a, input logic [31:0] d);
        int unsigned i;
        int unsigned n;
        i = a % (mem_words * 4);
        n = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            ref_mem[i + k] = d[8*k +: 8];
        end
    endtask

    // present, wait out the stall, queue the expected writeback
    task automatic run_uop(input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic vld);
        uop_t u;
        int   stalls;
        int   exp_stalls;
        u          = '0;
        u.valid    = vld;
        u.tag      = tag_cnt;
        u.op       = op;
        u.rd_idx   = 5'($random(seed));
        u.addr     = align_addr(op, addr);
        u.rs2_data = data;
        u.rd_data  = $random(seed);
        tag_cnt++;
        uop        = u;
        stalls     = 0;
        exp_stalls = (vld && op != op_none) ? int'(wait_cycles) + 2 : 0;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        assert (stalls == exp_stalls) else begin
            $display("mismatch stall_o cycles: got %h expected %h", stalls, exp_stalls);
            errors++;
        end
        if (vld) begin
            if (op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw}) begin
                u.rd_data = ref_load(op, u.addr);
            end else if (op != op_none) begin
                ref_store(op, u.addr, data);
            end
            exp_q.push_back(u);
        end
        @(posedge clk);
        #1;
        // writeback lands in the cycle right after acceptance
        assert (wb_uop.valid == vld && (!vld || wb_uop.tag == u.tag)) else begin
            $display("mismatch wb_uop_o.valid/tag: got %h/%h expected %h/%h",
                     wb_uop.valid, wb_uop.tag, vld, u.tag);
            errors++;
        end
    endtask

    // reset hits while a load sits in the apb setup phase
    task automatic reset_mid_transfer();
        uop_t u;
        u       = '0;
        u.valid = 1'b1;
        u.tag   = tag_cnt;
        u.op    = op_lw;
        tag_cnt++;
        uop     = u;
        @(posedge clk);
        #1;
        rstn = 1'b0;
        uop  = '0;
        @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (!stall && !wb_uop.valid && !mem_top_inst.apb_req.psel) else begin
            $display("stage not idle after a reset during a transfer");
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        uop_t exp_uop;
        if (rstn && wb_uop.valid) begin
            if (exp_q.size() == 0) begin
                $display("writeback with tag %h arrived that was never expected", wb_uop.tag);
                errors++;
            end else begin
                exp_uop = exp_q.pop_front();
                assert (wb_uop == exp_uop) else begin
                    $display("mismatch wb_uop_o: got %h expected %h", wb_uop, exp_uop);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", max_cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] d;
        int          assert_fails;
        rstn = 1'b0;
        uop  = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (!stall && !wb_uop.valid && !mem_top_inst.apb_req.psel) else begin
            $display("stage not idle after reset");
            errors++;
        end
        run_uop(op_none, $random(seed), $random(seed), 1'b1);
        run_uop(op_none, $random(seed), $random(seed), 1'b1);
        assert (!mem_top_inst.apb_req.psel) else begin
            $display("bus left idle before any memory micro-op");
            errors++;
        end
        for (int w = 0; w < 16; w++) begin
            run_uop(op_sw, 32'(4 * w), $random(seed), 1'b1);  // known contents
        end
        d = $random(seed);
        run_uop(op_sw, 32'h20, d, 1'b1);
        run_uop(op_lw, 32'h20, 32'h0, 1'b1);
        for (int l = 0; l < 6; l++) begin
            run_uop(op_sw, 32'h10, $random(seed), 1'b1);
            if (l < 4) begin
                run_uop(op_sb, 32'h10 + l, $random(seed), 1'b1);
            end else begin
                run_uop(op_sh, 32'h10 + 2 * (l - 4), $random(seed), 1'b1);
            end
            run_uop(op_lw, 32'h10, 32'h0, 1'b1);
        end
        for (int l = 0; l < 6; l++) begin
            for (int t = 0; t < 2; t++) begin
                d = $random(seed);
                if (l < 4) begin
                    d[7] = t[0];
                    run_uop(op_sb, 32'h18 + l, d, 1'b1);
                    run_uop(op_lb, 32'h18 + l, 32'h0, 1'b1);
                    run_uop(op_lbu, 32'h18 + l, 32'h0, 1'b1);
                end else begin
                    d[15] = t[0];
                    run_uop(op_sh, 32'h1c + 2 * (l - 4), d, 1'b1);
                    run_uop(op_lh, 32'h1c + 2 * (l - 4), 32'h0, 1'b1);
                    run_uop(op_lhu, 32'h1c + 2 * (l - 4), 32'h0, 1'b1);
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            run_uop(op_lw, 32'(4 * i), 32'h0, 1'b1);
            run_uop(op_none, $random(seed), $random(seed), 1'b1);
            run_uop(op_lb, 32'(4 * i + 1), 32'h0, 1'b0);  // dropped, no writeback
        end
        reset_mid_transfer();
        for (int i = 0; i < 200; i++) begin
            run_uop(mem_op_e'(4'($unsigned($random(seed)) % 9)), $random(seed) & 32'h3f,
                    $random(seed), ($random(seed) & 7) != 0);
        end
        uop = '0;
        repeat (3) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_q.size());
            errors++;
        end
        assert_fails = mem_top_inst.mem_stage_inst.mem_assert_inst.fail_cnt;
        $display("errors: %0d checks, %0d assertions", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_assert.sv */
`default_nettype none

module mem_assert (
    input logic              clk_i,
    input logic              rstn_i,
    input mem_pkg::uop_t     uop_i,
    input logic              stall_o,
    input mem_pkg::apb_req_t apb_req_o,
    input mem_pkg::apb_rsp_t apb_rsp_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    int fail_cnt = 0;

    logic half_op;
    logic word_op;

    assign half_op = uop_i.op inside {op_lh, op_lhu, op_sh};
    assign word_op = uop_i.op inside {op_lw, op_sw};

    // setup lasts exactly one cycle
    setup_to_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        apb_req_o.psel && !apb_req_o.penable |=> apb_req_o.psel && apb_req_o.penable)
        else begin
            $error("apb setup phase not followed by access phase");
            fail_cnt++;
        end

    hold_until_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        apb_req_o.psel && !(apb_req_o.penable && apb_rsp_i.pready)
        |=> apb_req_o.psel && $stable(apb_req_o.paddr) && $stable(apb_req_o.pwrite)
            && $stable(apb_req_o.pwdata) && $stable(apb_req_o.pstrb))
        else begin
            $error("apb address or control changed before pready");
            fail_cnt++;
        end

    stall_after_reset: assert property (@(posedge clk_i) !rstn_i |=> !stall_o)
        else begin
            $error("stall_o high right after reset");
            fail_cnt++;
        end

    // halfwords on even bytes, words on word boundaries
    aligned_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        uop_i.valid |-> !(half_op && uop_i.addr[0]) && !(word_op && uop_i.addr[1:0] != 2'b00))
        else begin
            $error("misaligned memory micro-op address %h", uop_i.addr);
            fail_cnt++;
        end

endmodule

bind mem_stage mem_assert mem_assert_inst (
    .clk_i     ( clk_i     ),
    .rstn_i    ( rstn_i    ),
    .uop_i     ( uop_i     ),
    .stall_o   ( stall_o   ),
    .apb_req_o ( apb_req_o ),
    .apb_rsp_i ( apb_rsp_i )
);

`default_nettype wire

/* src/mem_top.sv */
`default_nettype none

module mem_top #(
    parameter int unsigned mem_words   = 256,
    parameter int unsigned wait_cycles = 1
) (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  mem_pkg::uop_t uop_i,
    output logic          stall_o,
    output mem_pkg::uop_t wb_uop_o
);
    import mem_pkg::*;

    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // memory stage with its bus master
    mem_stage mem_stage_inst (
        .clk_i     ( clk_i    ),
        .rstn_i    ( rstn_i   ),
        .uop_i     ( uop_i    ),
        .stall_o   ( stall_o  ),
        .wb_uop_o  ( wb_uop_o ),
        .apb_req_o ( apb_req  ),
        .apb_rsp_i ( apb_rsp  )
    );

    data_ram #(
        .mem_words   ( mem_words   ),
        .wait_cycles ( wait_cycles )
    ) data_ram_inst (
        .clk_i     ( clk_i   ),
        .rstn_i    ( rstn_i  ),
        .apb_req_i ( apb_req ),
        .apb_rsp_o ( apb_rsp )
    );

endmodule

`default_nettype wire

/* src/data_ram.sv */
`default_nettype none

module data_ram #(
    parameter int unsigned mem_words   = 256,
    parameter int unsigned wait_cycles = 1
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  mem_pkg::apb_req_t apb_req_i,
    output mem_pkg::apb_rsp_t apb_rsp_o
);
    import mem_pkg::*;

    localparam int unsigned idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam int unsigned cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

    logic [xlen-1:0]  mem [mem_words];
    logic [idx_w-1:0] word_idx;
    logic [cnt_w-1:0] wait_cnt;
    logic             in_access;
    logic             ready;

    // paddr is word aligned, drop the byte offset
    assign word_idx  = idx_w'(apb_req_i.paddr[addr_width-1:2] % mem_words);
    assign in_access = apb_req_i.psel && apb_req_i.penable;
    assign ready     = in_access && (wait_cnt == cnt_w'(wait_cycles));

    // counts access cycles, restarts for every transfer
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wait_cnt <= '0;
        end else if (in_access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready && apb_req_i.pwrite) begin
            for (int i = 0; i < strb_width; i++) begin
                if (apb_req_i.pstrb[i]) begin
                    mem[word_idx][8*i +: 8] <= apb_req_i.pwdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        apb_rsp_o.pready  = ready;
        apb_rsp_o.pslverr = 1'b0;   // no error responses
        apb_rsp_o.prdata  = '0;
        if (ready && !apb_req_i.pwrite) begin
            apb_rsp_o.prdata = mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`default_nettype none

module mem_stage (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  mem_pkg::uop_t     uop_i,
    output logic              stall_o,
    output mem_pkg::uop_t     wb_uop_o,
    output mem_pkg::apb_req_t apb_req_o,
    input  mem_pkg::apb_rsp_t apb_rsp_i
);
    import mem_pkg::*;

    typedef enum logic {
        ready,
        wait_rsp
    } stage_state_e;

    stage_state_e state_q;
    stage_state_e state_d;

    uop_t wb_uop_q;
    uop_t wb_uop_d;

    logic                  is_read;
    logic                  is_write;
    logic                  is_mem;
    logic [strb_width-1:0] strb;
    logic [xlen-1:0]       wdata;
    logic                  req_valid;
    logic                  bus_busy;
    logic                  bus_done;
    logic [xlen-1:0]       bus_rdata;

    // pick byte or halfword out of the read word, then extend
    function automatic logic [xlen-1:0] load_extend(input mem_op_e         op,
                                                    input logic [1:0]      lo,
                                                    input logic [xlen-1:0] word);
        logic [7:0]      byte_sel;
        logic [15:0]     half_sel;
        logic [xlen-1:0] res;
        byte_sel = word[8*lo +: 8];
        half_sel = word[16*lo[1] +: 16];
        case (op)
            op_lb:   res = {{(xlen-8){byte_sel[7]}}, byte_sel};
            op_lbu:  res = {{(xlen-8){1'b0}}, byte_sel};
            op_lh:   res = {{(xlen-16){half_sel[15]}}, half_sel};
            op_lhu:  res = {{(xlen-16){1'b0}}, half_sel};
            default: res = word;   // lw
        endcase
        return res;
    endfunction

    lsu_decode lsu_decode_inst (
        .op_i         ( uop_i.op          ),
        .addr_lo_i    ( uop_i.addr[1:0]   ),
        .store_data_i ( uop_i.rs2_data    ),
        .is_read_o    ( is_read           ),
        .is_write_o   ( is_write          ),
        .strb_o       ( strb              ),
        .wdata_o      ( wdata             )
    );

    apb_bus_master apb_bus_master_inst (
        .clk_i       ( clk_i        ),
        .rstn_i      ( rstn_i       ),
        .req_valid_i ( req_valid    ),
        .req_write_i ( is_write     ),
        .req_addr_i  ( uop_i.addr   ),
        .req_wdata_i ( wdata        ),
        .req_strb_i  ( strb         ),
        .apb_req_o   ( apb_req_o    ),
        .apb_rsp_i   ( apb_rsp_i    ),
        .busy_o      ( bus_busy     ),
        .done_o      ( bus_done     ),
        .rdata_o     ( bus_rdata    )
    );

    assign is_mem = uop_i.valid && (is_read || is_write);

    always_comb begin
        state_d   = state_q;
        stall_o   = 1'b0;
        req_valid = 1'b0;
        wb_uop_d  = uop_i;
        case (state_q)
            ready: begin
                if (is_mem) begin
                    stall_o   = 1'b1;   // held until the bus is done
                    req_valid = !bus_busy;
                    if (!bus_busy) begin
                        state_d = wait_rsp;
                    end
                end
            end
            wait_rsp: begin
                stall_o = 1'b1;
                if (bus_done) begin
                    stall_o = 1'b0;
                    state_d = ready;
                    if (is_read) begin
                        wb_uop_d.rd_data = load_extend(uop_i.op, uop_i.addr[1:0], bus_rdata);
                    end
                end
            end
            default: begin
                state_d = ready;
            end
        endcase
        wb_uop_d.valid = uop_i.valid && !stall_o;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q  <= ready;
            wb_uop_q <= '0;
        end else begin
            state_q  <= state_d;
            wb_uop_q <= wb_uop_d;
        end
    end

    assign wb_uop_o = wb_uop_q;

endmodule

`default_nettype wire

/* src/apb_bus_master.sv */
`default_nettype none

module apb_bus_master (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          req_valid_i,
    input  logic                          req_write_i,
    input  logic [mem_pkg::addr_width-1:0] req_addr_i,
    input  logic [mem_pkg::xlen-1:0]       req_wdata_i,
    input  logic [mem_pkg::strb_width-1:0] req_strb_i,
    output mem_pkg::apb_req_t             apb_req_o,
    input  mem_pkg::apb_rsp_t             apb_rsp_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [mem_pkg::xlen-1:0]       rdata_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } bus_state_e;

    bus_state_e state_q;
    bus_state_e state_d;

    // request held for the whole transfer
    logic                  write_q;
    logic [addr_width-1:0] addr_q;
    logic [xlen-1:0]       wdata_q;
    logic [strb_width-1:0] strb_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (req_valid_i) begin
                    state_d = setup;
                end
            end
            setup: begin
                state_d = access;   // setup is always one cycle
            end
            access: begin
                if (apb_rsp_i.pready) begin
                    state_d = idle;
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == idle && req_valid_i) begin
            write_q <= req_write_i;
            addr_q  <= {req_addr_i[addr_width-1:2], 2'b00};  // word aligned
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
    end

    always_comb begin
        apb_req_o.psel    = (state_q != idle);
        apb_req_o.penable = (state_q == access);
        apb_req_o.pwrite  = write_q;
        apb_req_o.paddr   = addr_q;
        apb_req_o.pwdata  = wdata_q;
        apb_req_o.pstrb   = strb_q;
    end

    assign busy_o  = (state_q != idle);
    assign done_o  = (state_q == access) && apb_rsp_i.pready;
    assign rdata_o = apb_rsp_i.prdata;  // valid with done_o

endmodule

`default_nettype wire

/* src/lsu_decode.sv */
`default_nettype none

module lsu_decode (
    input  mem_pkg::mem_op_e              op_i,
    input  logic [1:0]                    addr_lo_i,
    input  logic [mem_pkg::xlen-1:0]       store_data_i,
    output logic                          is_read_o,
    output logic                          is_write_o,
    output logic [mem_pkg::strb_width-1:0] strb_o,
    output logic [mem_pkg::xlen-1:0]       wdata_o
);
    import mem_pkg::*;

    always_comb begin
        is_read_o  = 1'b0;
        is_write_o = 1'b0;
        strb_o     = '0;   // loads drive no strobes
        wdata_o    = store_data_i;
        case (op_i)
            op_lb,
            op_lbu,
            op_lh,
            op_lhu,
            op_lw: begin
                is_read_o = 1'b1;
            end
            op_sb: begin
                is_write_o = 1'b1;
                strb_o     = 4'b0001 << addr_lo_i;
                wdata_o    = {4{store_data_i[7:0]}};  // byte on every lane
            end
            op_sh: begin
                is_write_o = 1'b1;
                strb_o     = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                wdata_o    = {2{store_data_i[15:0]}};
            end
            op_sw: begin
                is_write_o = 1'b1;
                strb_o     = 4'b1111;
            end
            default: begin
                // op_none, nothing to do on the bus
                is_read_o  = 1'b0;
                is_write_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned addr_width = 32;
    localparam int unsigned strb_width = xlen / 8;

    // memory opcodes as they come out of execute
    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    // 112 bits in total
    typedef struct packed {
        logic                  valid;
        logic [5:0]            tag;
        mem_op_e               op;
        logic [4:0]            rd_idx;
        logic [addr_width-1:0] addr;      // byte address
        logic [xlen-1:0]       rs2_data;  // store data
        logic [xlen-1:0]       rd_data;   // result for writeback
    } uop_t;

    // master to slave
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [addr_width-1:0] paddr;
        logic [xlen-1:0]       pwdata;
        logic [strb_width-1:0] pstrb;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
